/* compile.f */
src/spi_pkg.sv
src/disp_pkg.sv
src/mem_if.sv
src/disp_if.sv
src/spi_slave.sv
src/byte_ram.sv
src/hex_scanner.sv
src/oled_serializer.sv
src/spi_ram_hex_top.sv
sim/tb_spi_ram_hex.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_spi_ram_hex -f compile.f -o tb_sim

# the simulator exits nonzero on $fatal, so keep its output for the search
out=$(./obj_dir/tb_sim) || true
echo "$out"

if echo "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1

/* sim/tb_spi_ram_hex.sv */
`timescale 1ns/100ps

module tb_spi_ram_hex
    import spi_pkg::*;
    import disp_pkg::*;
();
    localparam int ADDR_BITS = 8;
    localparam int HALF_SCLK = 4; // clk cycles per sclk half-period.
    localparam int SPI_BYTES = 59;
    localparam int WATCHDOG_CYCLES = SPI_BYTES * 64 + 3 * 17 * 18 + 1000;

    logic clk;
    logic arst_n;
    logic csn;
    logic sclk;
    logic mosi;
    logic miso;
    logic oled_csn;
    logic oled_clk;
    logic oled_mosi;
    logic oled_dc;

    logic [7:0]  model_ram [2**ADDR_BITS];
    logic [15:0] model_last_addr;
    logic [7:0]  tx_data [$];
    logic [7:0]  rx_data [$];
    logic [7:0]  disp_bytes [$];
    logic        disp_dc [$];
    logic [7:0]  disp_shift;
    int          disp_bits;
    logic        oled_clk_prev;

    spi_ram_hex_top #(.ADDR_BITS(ADDR_BITS)) dut_i
    (
        .clk       (clk),
        .arst_n    (arst_n),
        .csn       (csn),
        .sclk      (sclk),
        .mosi      (mosi),
        .miso      (miso),
        .oled_csn  (oled_csn),
        .oled_clk  (oled_clk),
        .oled_mosi (oled_mosi),
        .oled_dc   (oled_dc)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // rising oled_clk seen as a change between falling clk edges.
    always @(negedge clk)
    begin
        if (!arst_n || oled_csn)
            disp_bits = 0;
        else if (oled_clk && !oled_clk_prev)
        begin
            disp_shift = {disp_shift[6:0], oled_mosi};
            disp_bits++;
            if (disp_bits == 8)
            begin
                disp_bytes.push_back(disp_shift);
                disp_dc.push_back(oled_dc);
                disp_bits = 0;
            end
        end
        oled_clk_prev = oled_clk;
    end

    task automatic check_value(input logic [15:0] got, input logic [15:0] exp,
                               input string what);
        assert (got === exp)
        else
        begin
            $display("ERR %0t: %s got %0h expected %0h", $time, what, got, exp);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    function automatic logic [7:0] hex_ascii(input logic [3:0] n);
        if (n < 4'd10)
            return 8'h30 + 8'(n);
        else
            return 8'h41 + 8'(n - 4'd10); // "A" onward.
    endfunction

    function automatic logic [63:0] model_status();
        logic [63:0] st;
        st[15:0] = model_last_addr;
        for (int i = 0; i < 6; i++)
            st[16 + 8*i +: 8] = model_ram[i];
        return st;
    endfunction

    // mode-0 byte with mosi set while sclk is low and miso taken as sclk rises.
    task automatic spi_xfer_byte(input logic [7:0] tx, output logic [7:0] rx);
        for (int i = 7; i >= 0; i--)
        begin
            sclk = 1'b0;
            mosi = tx[i];
            repeat (HALF_SCLK) @(negedge clk);
            rx[i] = miso;
            sclk = 1'b1;
            repeat (HALF_SCLK) @(negedge clk);
        end
    endtask

    task automatic spi_begin(input logic [7:0] cmd, input logic [15:0] addr);
        logic [7:0] unused;
        csn = 1'b0;
        repeat (HALF_SCLK) @(negedge clk);
        spi_xfer_byte(cmd, unused);
        spi_xfer_byte(addr[15:8], unused);
        spi_xfer_byte(addr[7:0], unused);
    endtask

    task automatic spi_end();
        sclk = 1'b0;
        repeat (HALF_SCLK) @(negedge clk);
        csn = 1'b1;
        repeat (2 * HALF_SCLK) @(negedge clk);
    endtask

    task automatic spi_write(input logic [15:0] addr);
        logic [7:0]  unused;
        logic [15:0] a;
        spi_begin(SPI_WRITE, addr);
        for (int i = 0; i < tx_data.size(); i++)
        begin
            a = addr + 16'(i);
            spi_xfer_byte(tx_data[i], unused);
            model_ram[a[ADDR_BITS-1:0]] = tx_data[i];
            model_last_addr = a;
        end
        spi_end();
    endtask

    task automatic spi_read(input logic [15:0] addr, input int n);
        logic [7:0] b;
        rx_data.delete();
        spi_begin(SPI_READ, addr);
        for (int i = 0; i < n; i++)
        begin
            spi_xfer_byte(8'h00, b);
            rx_data.push_back(b);
        end
        spi_end();
    endtask

    task automatic verify_read(input logic [15:0] addr, input int n);
        logic [15:0] a;
        spi_read(addr, n);
        for (int i = 0; i < n; i++)
        begin
            a = addr + 16'(i);
            check_value(rx_data[i], model_ram[a[ADDR_BITS-1:0]],
                        $sformatf("read at %04h", a));
        end
    endtask

    task automatic next_disp_byte(output logic [7:0] b, output logic dc);
        while (disp_bytes.size() == 0)
            @(posedge clk);
        b  = disp_bytes.pop_front();
        dc = disp_dc.pop_front();
    endtask

    // the first home byte may belong to a frame snapped before the last write.
    task automatic check_frame();
        logic [63:0] st;
        logic [7:0]  b;
        logic        dc;
        int          homes;
        st    = model_status();
        homes = 0;
        @(posedge clk);
        disp_bytes.delete();
        disp_dc.delete();
        while (homes < 2)
        begin
            next_disp_byte(b, dc);
            if (!dc)
                homes++;
        end
        check_value(b, DISP_HOME, "frame command byte");
        for (int n = DISP_CHARS - 1; n >= 0; n--)
        begin
            next_disp_byte(b, dc);
            check_value(dc, 1'b1, $sformatf("dc of character %0d", n));
            check_value(b, hex_ascii(st[4*n +: 4]), $sformatf("character %0d", n));
        end
    endtask

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the tests did not finish in %0d clock cycles", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $fatal(1);
    end

    initial
    begin
        logic [7:0] unused;
        logic [7:0] alias_byte;
        void'($urandom(32'h825e02e7));
        csn    = 1'b1;
        sclk   = 1'b0;
        mosi   = 1'b0;
        arst_n = 1'b0;
        for (int i = 0; i < 2**ADDR_BITS; i++)
            model_ram[i] = 8'h00; // status bytes 0 to 5 reset to 0.
        model_last_addr = 16'h0000;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_value(miso, 1'b0, "miso after reset");
        check_value(oled_csn, 1'b1, "oled_csn after reset");
        check_value(oled_clk, 1'b0, "oled_clk after reset");

        tx_data.delete();
        tx_data.push_back(8'hA5);
        spi_write(16'h0040);
        verify_read(16'h0040, 1);

        tx_data.delete();
        for (int i = 0; i < 8; i++)
            tx_data.push_back(8'($urandom));
        spi_write(16'h0002);
        verify_read(16'h0002, 8);

        alias_byte = 8'($urandom);
        tx_data.delete();
        tx_data.push_back(alias_byte);
        spi_write(16'h0105);
        spi_read(16'h0005, 1);
        check_value(rx_data[0], alias_byte, "aliased read at 0005");

        tx_data.delete();
        for (int i = 0; i < 4; i++)
            tx_data.push_back(8'($urandom));
        spi_write(16'h0080);
        // unknown command followed by bytes that would look like an address and data.
        csn = 1'b0;
        repeat (HALF_SCLK) @(negedge clk);
        spi_xfer_byte(8'h5A, unused);
        spi_xfer_byte(8'h00, unused);
        spi_xfer_byte(8'h80, unused);
        for (int i = 0; i < 4; i++)
            spi_xfer_byte(8'hFF, unused);
        spi_end();
        verify_read(16'h0080, 4);

        check_frame();

        $display("TEST PASS");
        $finish;
    end

endmodule

/* src/spi_ram_hex_top.sv */
`timescale 1ns/100ps

module spi_ram_hex_top
    import disp_pkg::*;
#(
    parameter int ADDR_BITS = 8
)
(
    input  logic clk,
    input  logic arst_n,
    input  logic csn,
    input  logic sclk,
    input  logic mosi,
    output logic miso,
    output logic oled_csn,
    output logic oled_clk,
    output logic oled_mosi,
    output logic oled_dc
);
    logic [STATUS_W-1:0] status;

    mem_if  mem_bus ();
    disp_if disp_bus ();

    spi_slave spi_slave_i
    (
        .clk    (clk),
        .arst_n (arst_n),
        .csn    (csn),
        .sclk   (sclk),
        .mosi   (mosi),
        .miso   (miso),
        .mem    (mem_bus.master)
    );

    byte_ram
    #(
        .ADDR_BITS (ADDR_BITS)
    )
    byte_ram_i
    (
        .clk    (clk),
        .arst_n (arst_n),
        .mem    (mem_bus.ram),
        .status (status)
    );

    hex_scanner hex_scanner_i
    (
        .clk    (clk),
        .arst_n (arst_n),
        .status (status),
        .disp   (disp_bus.source)
    );

    oled_serializer oled_serializer_i
    (
        .clk       (clk),
        .arst_n    (arst_n),
        .disp      (disp_bus.sink),
        .oled_csn  (oled_csn),
        .oled_clk  (oled_clk),
        .oled_mosi (oled_mosi),
        .oled_dc   (oled_dc)
    );

endmodule

/* src/oled_serializer.sv */
`timescale 1ns/100ps

module oled_serializer
(
    input  logic clk,
    input  logic arst_n,
    disp_if.sink disp,
    output logic oled_csn,
    output logic oled_clk,
    output logic oled_mosi,
    output logic oled_dc
);
    logic [3:0] phase; // two steps per bit.
    logic       busy_q;
    logic [7:0] shreg;
    logic       dc_q;
    logic       last;

    assign last = (phase == 4'd15);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            busy_q   <= 1'b0;
            oled_csn <= 1'b1;
            oled_clk <= 1'b0;
            phase    <= '0;
        end
        else if (!busy_q)
        begin
            if (disp.start)
            begin
                busy_q   <= 1'b1;
                oled_csn <= 1'b0;
                oled_clk <= 1'b0;
                phase    <= '0;
            end
        end
        else if (last)
        begin
            busy_q   <= 1'b0; // last rising edge just passed.
            oled_csn <= 1'b1;
            oled_clk <= 1'b0;
        end
        else
        begin
            phase    <= phase + 1'b1;
            oled_clk <= ~oled_clk;
        end
    end

    always_ff @(posedge clk)
    begin
        if (disp.start && !busy_q)
        begin
            shreg <= disp.tx_byte;
            dc_q  <= disp.dc;
        end
        else if (busy_q && oled_clk && !last)
            shreg <= {shreg[6:0], 1'b0}; // next bit as the clock falls.
    end

    assign disp.busy = busy_q;
    assign oled_mosi = shreg[7];
    assign oled_dc   = dc_q;

endmodule

/* src/hex_scanner.sv */
`timescale 1ns/100ps

module hex_scanner
    import disp_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n,
    input  logic [STATUS_W-1:0] status,
    disp_if.source              disp
);
    localparam int CNT_W = $clog2(DISP_CHARS + 1);
    localparam int NIB_W = $clog2(DISP_CHARS);

    scan_state_e         state;
    logic [STATUS_W-1:0] snap;
    logic [CNT_W-1:0]    chars_left;
    logic [NIB_W-1:0]    nib_idx;
    logic [3:0]          nibble;
    logic [7:0]          ascii;
    logic                start_q;
    logic [7:0]          byte_q;
    logic                dc_q;
    logic                idle;

    assign nib_idx = NIB_W'(chars_left - 1'b1); // most significant nibble first.
    assign nibble  = snap[{nib_idx, 2'b00} +: 4];
    assign ascii   = (nibble < 4'd10) ? 8'h30 + {4'h0, nibble} : 8'h37 + {4'h0, nibble};
    assign idle    = !disp.busy && !start_q; // busy only rises a cycle after start.

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state      <= SC_IDLE;
            snap       <= '0;
            chars_left <= '0;
            start_q    <= 1'b0;
            byte_q     <= '0;
            dc_q       <= 1'b0;
        end
        else
        begin
            start_q <= 1'b0;
            case (state)
                SC_IDLE:
                begin
                    snap  <= status;
                    state <= SC_CMD;
                end
                SC_CMD:
                    if (idle)
                    begin
                        start_q    <= 1'b1;
                        byte_q     <= DISP_HOME;
                        dc_q       <= 1'b0;
                        chars_left <= CNT_W'(DISP_CHARS);
                        state      <= SC_CHAR;
                    end
                SC_CHAR:
                    if (idle)
                    begin
                        start_q    <= 1'b1;
                        byte_q     <= ascii;
                        dc_q       <= 1'b1;
                        chars_left <= chars_left - 1'b1;
                        if (chars_left == CNT_W'(1))
                            state <= SC_WAIT;
                    end
                default:
                    if (idle)
                    begin
                        snap  <= status; // frozen for the whole next frame.
                        state <= SC_CMD;
                    end
            endcase
        end
    end

    assign disp.start   = start_q;
    assign disp.tx_byte = byte_q;
    assign disp.dc      = dc_q;

endmodule

/* src/byte_ram.sv */
`timescale 1ns/100ps

module byte_ram
    import spi_pkg::*;
    import disp_pkg::*;
#(
    parameter int ADDR_BITS = 8
)
(
    input  logic                clk,
    input  logic                arst_n,
    mem_if.ram                  mem,
    output logic [STATUS_W-1:0] status
);
    localparam int DEPTH    = 2 ** ADDR_BITS;
    localparam int SHADOW_N = 6; // bytes 0 to 5 shown on the display.

    logic [DATA_W-1:0]     ram [DEPTH];
    logic [DATA_W-1:0]     rdata_q;
    logic [DATA_W-1:0]     shadow [SHADOW_N];
    logic [SPI_ADDR_W-1:0] last_addr;
    logic [ADDR_BITS-1:0]  idx;

    assign idx = mem.addr[ADDR_BITS-1:0]; // upper address bits alias.

    always_ff @(posedge clk)
    begin
        if (mem.wr)
            ram[idx] <= mem.wdata;
        if (mem.rd)
            rdata_q <= ram[idx];
    end

    assign mem.rdata = rdata_q;

    // copies of the low bytes feed the status word without a read port.
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            last_addr <= '0;
            for (int i = 0; i < SHADOW_N; i++)
                shadow[i] <= '0;
        end
        else if (mem.wr)
        begin
            last_addr <= mem.addr;
            for (int i = 0; i < SHADOW_N; i++)
                if (idx == ADDR_BITS'(i))
                    shadow[i] <= mem.wdata;
        end
    end

    always_comb
    begin
        status[SPI_ADDR_W-1:0] = last_addr;
        for (int i = 0; i < SHADOW_N; i++)
            status[SPI_ADDR_W + DATA_W*i +: DATA_W] = shadow[i];
    end

endmodule

/* src/spi_slave.sv */
`timescale 1ns/100ps

module spi_slave
    import spi_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  csn,
    input  logic  sclk,
    input  logic  mosi,
    output logic  miso,
    mem_if.master mem
);
    localparam int BIT_W = $clog2(DATA_W);

    logic [2:0]            sclk_q;
    logic [1:0]            mosi_q;
    logic [1:0]            csn_q;
    logic                  sclk_rise;
    logic                  sclk_fall;
    logic                  csn_s;
    logic [BIT_W-1:0]      bit_cnt;
    logic [DATA_W-1:0]     rx_shift;
    logic [DATA_W-1:0]     rx_byte;
    logic                  byte_done;
    logic [DATA_W-1:0]     tx_shift;
    spi_state_e            state;
    logic                  read_mode;
    logic [SPI_ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0]     wdata_q;
    logic                  wr_q;
    logic                  rd_q;
    logic                  rd_d;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sclk_q <= '0;
            mosi_q <= '0;
            csn_q  <= 2'b11; // deselected.
        end
        else
        begin
            sclk_q <= {sclk_q[1:0], sclk};
            mosi_q <= {mosi_q[0], mosi};
            csn_q  <= {csn_q[0], csn};
        end
    end

    assign sclk_rise = sclk_q[1] & ~sclk_q[2];
    assign sclk_fall = ~sclk_q[1] & sclk_q[2];
    assign csn_s     = csn_q[1];
    assign rx_byte   = {rx_shift[DATA_W-2:0], mosi_q[1]};
    assign byte_done = sclk_rise && (bit_cnt == BIT_W'(DATA_W - 1)) && !csn_s;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state     <= ST_CMD;
            bit_cnt   <= '0;
            rx_shift  <= '0;
            tx_shift  <= '0;
            miso      <= 1'b0;
            read_mode <= 1'b0;
            addr_q    <= '0;
            wdata_q   <= '0;
            wr_q      <= 1'b0;
            rd_q      <= 1'b0;
            rd_d      <= 1'b0;
        end
        else
        begin
            wr_q <= 1'b0;
            rd_q <= 1'b0;
            rd_d <= rd_q;
            if (csn_s)
            begin
                state    <= ST_CMD;
                bit_cnt  <= '0;
                tx_shift <= '0;
                miso     <= 1'b0;
            end
            else
            begin
                if (sclk_rise)
                begin
                    rx_shift <= rx_byte;
                    bit_cnt  <= bit_cnt + 1'b1;
                end
                if (sclk_fall)
                begin
                    miso     <= tx_shift[DATA_W-1];
                    tx_shift <= {tx_shift[DATA_W-2:0], 1'b0};
                end
                if (rd_d)
                begin
                    tx_shift <= mem.rdata; // prefetched byte for the next slot.
                    addr_q   <= addr_q + 1'b1;
                end
                if (wr_q)
                    addr_q <= addr_q + 1'b1;
                if (byte_done)
                begin
                    case (state)
                        ST_CMD:
                        begin
                            case (rx_byte)
                                SPI_WRITE:
                                begin
                                    read_mode <= 1'b0;
                                    state     <= ST_ADDR_HI;
                                end
                                SPI_READ:
                                begin
                                    read_mode <= 1'b1;
                                    state     <= ST_ADDR_HI;
                                end
                                default: state <= ST_IGNORE;
                            endcase
                        end
                        ST_ADDR_HI:
                        begin
                            addr_q[SPI_ADDR_W-1:8] <= rx_byte;
                            state                  <= ST_ADDR_LO;
                        end
                        ST_ADDR_LO:
                        begin
                            addr_q[7:0] <= rx_byte;
                            rd_q        <= read_mode;
                            state       <= ST_DATA;
                        end
                        ST_DATA:
                        begin
                            if (read_mode)
                                rd_q <= 1'b1;
                            else
                            begin
                                wdata_q <= rx_byte;
                                wr_q    <= 1'b1;
                            end
                        end
                        default: ; // stays ignored until csn rises.
                    endcase
                end
            end
        end
    end

    assign mem.wr    = wr_q;
    assign mem.rd    = rd_q;
    assign mem.addr  = addr_q;
    assign mem.wdata = wdata_q;

endmodule

/* src/disp_if.sv */
`timescale 1ns/100ps

interface disp_if ();
    logic       start;   // one-cycle pulse while busy is low.
    logic [7:0] tx_byte;
    logic       dc;      // low for commands.
    logic       busy;

    modport source (output start, output tx_byte, output dc, input busy);
    modport sink (input start, input tx_byte, input dc, output busy);

endinterface

/* src/mem_if.sv */
`timescale 1ns/100ps

interface mem_if
    import spi_pkg::*;
();
    logic                  wr;    // one-cycle write strobe.
    logic                  rd;    // one-cycle read strobe.
    logic [SPI_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]     wdata;
    logic [DATA_W-1:0]     rdata; // valid the cycle after rd.

    modport master (output wr, output rd, output addr, output wdata, input rdata);
    modport ram (input wr, input rd, input addr, input wdata, output rdata);

endinterface

/* src/disp_pkg.sv */
package disp_pkg;

    localparam int DISP_CHARS = 16; // hex characters per frame.
    localparam int STATUS_W = 64;

    // command bytes go out with dc low.
    typedef enum logic [7:0]
    {
        DISP_HOME = 8'h02
    } disp_op_e;

    typedef enum logic [1:0]
    {
        SC_IDLE,
        SC_CMD,
        SC_CHAR,
        SC_WAIT
    } scan_state_e;

endpackage

/* src/spi_pkg.sv */
package spi_pkg;

    localparam int SPI_ADDR_W = 16; // host address width.
    localparam int DATA_W = 8;

    // first byte of every SPI transfer.
    typedef enum logic [7:0]
    {
        SPI_WRITE = 8'h00,
        SPI_READ  = 8'h01
    } spi_cmd_e;

    typedef enum logic [2:0]
    {
        ST_CMD,
        ST_ADDR_HI,
        ST_ADDR_LO,
        ST_DATA,
        ST_IGNORE // waits for csn after an unknown command.
    } spi_state_e;

endpackage
